/* rtl/lc3b_isa_pkg.sv */
package lc3b_isa_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;

    // standard lc-3b opcode map
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // operate instruction, register source
    typedef struct packed {
        lc3b_opcode  opcode;
        lc3b_reg     dest;
        lc3b_reg     src1;
        logic        imm_flag;
        logic [1:0]  unused;
        lc3b_reg     src2;
    } lc3b_instr_reg_t;

    // operate instruction, immediate source
    // for shf, imm_flag is the direction bit and imm5[4] the arithmetic bit
    typedef struct packed {
        lc3b_opcode  opcode;
        lc3b_reg     dest;
        lc3b_reg     src1;
        logic        imm_flag;
        logic [4:0]  imm5;
    } lc3b_instr_imm_t;

    typedef union packed {
        lc3b_instr_reg_t r;
        lc3b_instr_imm_t i;
    } lc3b_instr_u;

    // br with no condition bits set, never writes
    localparam lc3b_word C_NOP_INSTR = 16'h0000;

endpackage : lc3b_isa_pkg

/* rtl/lc3b_pipe_pkg.sv */
package lc3b_pipe_pkg;

    import lc3b_isa_pkg::*;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_aluop;

    // n, z, p from msb to lsb
    typedef logic [2:0] lc3b_nzp;

    typedef struct packed {
        logic       valid;
        logic       load_regfile;
        lc3b_aluop  aluop;
        logic       use_imm;
    } lc3b_ctrl_t;

    typedef struct packed {
        logic        valid;
        lc3b_instr_u instr;
    } lc3b_ifid_t;

    typedef struct packed {
        lc3b_ctrl_t ctrl;
        lc3b_reg    dest;
        lc3b_reg    src1;
        lc3b_reg    src2;
        lc3b_word   src1_data;
        lc3b_word   src2_data;
        lc3b_word   imm;
    } lc3b_idex_t;

    // ex/wb register contents, also the register file write port
    typedef struct packed {
        logic     we;
        lc3b_reg  dest;
        lc3b_word data;
    } lc3b_wb_t;

endpackage : lc3b_pipe_pkg

/* rtl/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit #(
    parameter lc3b_isa_pkg::lc3b_word P_RESET_PC = 16'h0000
) (
    input  logic                        clk,
    input  logic                        i_arst_n,
    input  logic                        i_imem_resp,
    input  lc3b_isa_pkg::lc3b_word      i_imem_rdata,
    output logic                        o_imem_read,
    output lc3b_isa_pkg::lc3b_word      o_imem_address,
    output lc3b_pipe_pkg::lc3b_ifid_t   o_ifid
);
    import lc3b_isa_pkg::*;

    lc3b_word    pc;
    lc3b_word    pc_plus2;
    logic        read_en;
    logic        fetched;
    logic        ifid_valid;
    lc3b_instr_u ifid_instr;

    assign pc_plus2 = pc + 16'd2;
    assign fetched  = i_imem_resp & read_en;

    // pc only moves on a response, so the address holds until then
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc         <= P_RESET_PC;
            read_en    <= 1'b0;
            ifid_valid <= 1'b0;
        end else begin
            read_en    <= 1'b1;
            ifid_valid <= fetched;
            if (fetched) begin
                pc <= pc_plus2;
            end
        end
    end

    // bubble when memory is still busy
    always_ff @(posedge clk) begin
        if (fetched) begin
            ifid_instr <= i_imem_rdata;
        end else begin
            ifid_instr <= C_NOP_INSTR;
        end
    end

    assign o_imem_read    = read_en;
    assign o_imem_address = pc;
    assign o_ifid.valid   = ifid_valid;
    assign o_ifid.instr   = ifid_instr;

endmodule : fetch_unit

/* rtl/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
    input  logic                        clk,
    input  logic                        i_arst_n,
    input  lc3b_pipe_pkg::lc3b_ifid_t   i_ifid,
    output lc3b_isa_pkg::lc3b_reg       o_src1,
    output lc3b_isa_pkg::lc3b_reg       o_src2,
    input  lc3b_isa_pkg::lc3b_word      i_src1_data,
    input  lc3b_isa_pkg::lc3b_word      i_src2_data,
    output lc3b_pipe_pkg::lc3b_idex_t   o_idex
);
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;

    lc3b_instr_u instr;
    lc3b_ctrl_t  ctrl;
    lc3b_word    imm;
    lc3b_ctrl_t  ctrl_q;
    lc3b_reg     dest_q;
    lc3b_reg     src1_q;
    lc3b_reg     src2_q;
    lc3b_word    src1_data_q;
    lc3b_word    src2_data_q;
    lc3b_word    imm_q;

    assign instr  = i_ifid.instr;
    assign o_src1 = instr.r.src1;
    assign o_src2 = instr.r.src2;

    always_comb begin
        ctrl              = '0;
        ctrl.valid        = i_ifid.valid;
        ctrl.aluop        = alu_add;
        case (instr.r.opcode)
            op_add: begin
                ctrl.load_regfile = 1'b1;
                ctrl.use_imm      = instr.i.imm_flag;
            end
            op_and: begin
                ctrl.load_regfile = 1'b1;
                ctrl.aluop        = alu_and;
                ctrl.use_imm      = instr.i.imm_flag;
            end
            op_not: begin
                ctrl.load_regfile = 1'b1;
                ctrl.aluop        = alu_not;
            end
            op_shf: begin
                ctrl.load_regfile = 1'b1;
                ctrl.use_imm      = 1'b1;
                // direction in bit 5, arithmetic in bit 4
                if (!instr.i.imm_flag) begin
                    ctrl.aluop = alu_sll;
                end else if (instr.i.imm5[4]) begin
                    ctrl.aluop = alu_sra;
                end else begin
                    ctrl.aluop = alu_srl;
                end
            end
            default: begin
                ctrl.load_regfile = 1'b0;
            end
        endcase
    end

    // imm4 for shifts, sign-extended imm5 otherwise
    assign imm = (instr.i.opcode == op_shf) ? {12'h000, instr.i.imm5[3:0]}
                                            : {{11{instr.i.imm5[4]}}, instr.i.imm5};

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= ctrl;
        end
    end

    always_ff @(posedge clk) begin
        dest_q      <= instr.r.dest;
        src1_q      <= instr.r.src1;
        src2_q      <= instr.r.src2;
        src1_data_q <= i_src1_data;
        src2_data_q <= i_src2_data;
        imm_q       <= imm;
    end

    assign o_idex.ctrl      = ctrl_q;
    assign o_idex.dest      = dest_q;
    assign o_idex.src1      = src1_q;
    assign o_idex.src2      = src2_q;
    assign o_idex.src1_data = src1_data_q;
    assign o_idex.src2_data = src2_data_q;
    assign o_idex.imm       = imm_q;

endmodule : decode_stage

/* rtl/regfile.sv */
`timescale 1ns/10ps

module regfile (
    input  logic                      clk,
    input  logic                      i_arst_n,
    input  lc3b_pipe_pkg::lc3b_wb_t   i_wb,
    input  lc3b_isa_pkg::lc3b_reg     i_src1,
    input  lc3b_isa_pkg::lc3b_reg     i_src2,
    output lc3b_isa_pkg::lc3b_word    o_src1_data,
    output lc3b_isa_pkg::lc3b_word    o_src2_data
);
    import lc3b_isa_pkg::*;

    lc3b_word regs [8];

    // a write in the same cycle wins over the stored value
    function automatic lc3b_word read_port(lc3b_reg idx);
        if (i_wb.we && (i_wb.dest == idx)) begin
            return i_wb.data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.we) begin
            regs[i_wb.dest] <= i_wb.data;
        end
    end

    always_comb begin
        o_src1_data = read_port(i_src1);
        o_src2_data = read_port(i_src2);
    end

endmodule : regfile

/* rtl/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
    input  logic                        clk,
    input  logic                        i_arst_n,
    input  lc3b_pipe_pkg::lc3b_idex_t   i_idex,
    input  lc3b_pipe_pkg::lc3b_wb_t     i_wb,
    output lc3b_pipe_pkg::lc3b_wb_t     o_wb
);
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;

    lc3b_word   fwd_a;
    lc3b_word   fwd_b;
    lc3b_word   op_a;
    lc3b_word   op_b;
    lc3b_word   alu_out;
    logic [3:0] shamt;
    logic       we_q;
    lc3b_reg    dest_q;
    lc3b_word   data_q;

    // only one producer ahead of execute, the writeback stage
    function automatic lc3b_word forward(lc3b_reg idx, lc3b_word reg_data);
        if (i_wb.we && (i_wb.dest == idx)) begin
            return i_wb.data;
        end
        return reg_data;
    endfunction

    always_comb begin
        fwd_a = forward(i_idex.src1, i_idex.src1_data);
        fwd_b = forward(i_idex.src2, i_idex.src2_data);
    end

    assign op_a  = fwd_a;
    assign op_b  = i_idex.ctrl.use_imm ? i_idex.imm : fwd_b;
    assign shamt = op_b[3:0];

    always_comb begin
        case (i_idex.ctrl.aluop)
            alu_add: alu_out = op_a + op_b;
            alu_and: alu_out = op_a & op_b;
            alu_not: alu_out = ~op_a;
            alu_sll: alu_out = op_a << shamt;
            alu_srl: alu_out = op_a >> shamt;
            // sign bit fills from the left
            alu_sra: alu_out = $signed(op_a) >>> shamt;
            default: alu_out = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            we_q <= 1'b0;
        end else begin
            we_q <= i_idex.ctrl.valid & i_idex.ctrl.load_regfile;
        end
    end

    always_ff @(posedge clk) begin
        dest_q <= i_idex.dest;
        data_q <= alu_out;
    end

    assign o_wb.we   = we_q;
    assign o_wb.dest = dest_q;
    assign o_wb.data = data_q;

endmodule : execute_stage

/* rtl/writeback_stage.sv */
`timescale 1ns/10ps

module writeback_stage (
    input  logic                      clk,
    input  logic                      i_arst_n,
    input  lc3b_pipe_pkg::lc3b_wb_t   i_wb,
    output lc3b_pipe_pkg::lc3b_wb_t   o_wb,
    output lc3b_pipe_pkg::lc3b_nzp    o_cc
);
    import lc3b_pipe_pkg::*;

    lc3b_nzp gen_cc;
    lc3b_nzp cc_q;

    always_comb begin
        if (i_wb.data[15]) begin
            gen_cc = 3'b100;
        end else if (i_wb.data == '0) begin
            gen_cc = 3'b010;
        end else begin
            gen_cc = 3'b001;
        end
    end

    // holds the code of the last instruction that wrote a register
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cc_q <= '0;
        end else if (i_wb.we) begin
            cc_q <= gen_cc;
        end
    end

    // the writing instruction shows its cc in the same cycle as its result
    assign o_cc = i_wb.we ? gen_cc : cc_q;
    assign o_wb = i_wb;

endmodule : writeback_stage

/* rtl/lc3b_core.sv */
`timescale 1ns/10ps

module lc3b_core #(
    parameter lc3b_isa_pkg::lc3b_word P_RESET_PC = 16'h3000
) (
    input  logic                      clk,
    input  logic                      i_arst_n,
    input  logic                      i_imem_resp,
    input  lc3b_isa_pkg::lc3b_word    i_imem_rdata,
    output logic                      o_imem_read,
    output lc3b_isa_pkg::lc3b_word    o_imem_address,
    output lc3b_pipe_pkg::lc3b_wb_t   o_wb,
    output lc3b_pipe_pkg::lc3b_nzp    o_cc
);
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;

    lc3b_ifid_t ifid;
    lc3b_idex_t idex;
    lc3b_wb_t   ex_wb;
    lc3b_wb_t   wb;
    lc3b_reg    src1;
    lc3b_reg    src2;
    lc3b_word   src1_data;
    lc3b_word   src2_data;

    fetch_unit #(
        .P_RESET_PC(P_RESET_PC)
    ) u_fetch_unit (
        .clk,
        .i_arst_n,
        .i_imem_resp,
        .i_imem_rdata,
        .o_imem_read,
        .o_imem_address,
        .o_ifid(ifid)
    );

    decode_stage u_decode_stage (
        .clk,
        .i_arst_n,
        .i_ifid(ifid),
        .o_src1(src1),
        .o_src2(src2),
        .i_src1_data(src1_data),
        .i_src2_data(src2_data),
        .o_idex(idex)
    );

    regfile u_regfile (
        .clk,
        .i_arst_n,
        .i_wb(wb),
        .i_src1(src1),
        .i_src2(src2),
        .o_src1_data(src1_data),
        .o_src2_data(src2_data)
    );

    // writeback result comes back for forwarding
    execute_stage u_execute_stage (
        .clk,
        .i_arst_n,
        .i_idex(idex),
        .i_wb(wb),
        .o_wb(ex_wb)
    );

    writeback_stage u_writeback_stage (
        .clk,
        .i_arst_n,
        .i_wb(ex_wb),
        .o_wb(wb),
        .o_cc
    );

    assign o_wb = wb;

endmodule : lc3b_core

/* tests/lc3b_core_chk.sv */
`timescale 1ns/10ps

module lc3b_core_chk (
    input logic                     clk,
    input logic                     i_arst_n,
    input logic                     i_imem_resp,
    input logic                     o_imem_read,
    input lc3b_isa_pkg::lc3b_word   o_imem_address,
    input lc3b_pipe_pkg::lc3b_wb_t  o_wb
);
    int n_fail = 0;

    // request address held until the memory answers
    a_addr_stable: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (o_imem_read && !i_imem_resp) |=> $stable(o_imem_address)
    ) else begin
        n_fail++;
        $error("fetch address changed before the memory responded");
    end

    // pipeline starts empty
    a_no_write_after_reset: assert property (
        @(posedge clk) $rose(i_arst_n) |-> !o_wb.we
    ) else begin
        n_fail++;
        $error("register write in the first cycle after reset release");
    end

    a_no_read_in_reset: assert property (
        @(posedge clk) !i_arst_n |-> !o_imem_read
    ) else begin
        n_fail++;
        $error("instruction read requested while in reset");
    end

endmodule : lc3b_core_chk

bind lc3b_core lc3b_core_chk u_lc3b_core_chk (.*);

/* tests/tb_lc3b_core.sv */
`timescale 1ns/10ps

module tb_lc3b_core;
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;

    localparam lc3b_word P_RESET_PC = 16'h3000;
    localparam int N_INSTR    = 200;
    localparam int MAX_CYCLES = N_INSTR * 5 + 50;
    localparam int T_RESET = 0;
    localparam int T_FETCH = 1;
    localparam int T_REG   = 2;
    localparam int T_SHF   = 3;
    localparam int T_CC    = 4;
    localparam int T_DONE  = 5;

    logic     clk;
    logic     i_arst_n;
    logic     i_imem_resp;
    lc3b_word i_imem_rdata;
    logic     o_imem_read;
    lc3b_word o_imem_address;
    lc3b_wb_t o_wb;
    lc3b_nzp  o_cc;

    lc3b_word prog_mem [N_INSTR];
    lc3b_word model_regs [8];
    lc3b_wb_t exp_q [$];
    int       kind_q [$];
    string    test_name [6];
    int       checks [6];
    int       errors [6];
    int       seed;
    int       cycle;
    int       wait_cnt;
    int       next_delay;
    int       fetch_cnt;
    int       write_cnt;
    int       exp_cnt;
    int       drain_cnt;
    logic     first_cycle;
    logic     done;
    lc3b_word exp_addr;
    lc3b_nzp  last_cc;
    lc3b_wb_t exp_ent;
    int       exp_kind;

    lc3b_core #(
        .P_RESET_PC(P_RESET_PC)
    ) u_lc3b_core (
        .*
    );

    always #20 clk = ~clk;

    function automatic lc3b_nzp nzp_of(lc3b_word d);
        if (d[15]) begin
            return 3'b100;
        end else if (d == 16'h0000) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    // operate mix with frequent reuse of the previous destination
    function automatic lc3b_word make_instr(logic [31:0] r, lc3b_reg prev);
        lc3b_reg    dr;
        lc3b_reg    sa;
        lc3b_reg    sb;
        logic [3:0] opc;
        logic [1:0] dir;
        dr = r[6:4];
        sa = r[7] ? prev : r[10:8];
        sb = r[14] ? prev : r[13:11];
        case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7: begin
                opc = r[2] ? 4'b0101 : 4'b0001;
                if (r[15]) begin
                    return {opc, dr, sa, 1'b1, r[20:16]};
                end
                return {opc, dr, sa, 3'b000, sb};
            end
            4'd8, 4'd9: return {4'b1001, dr, sa, 6'b111111};
            4'd15: begin
                opc = r[18] ? (r[17] ? 4'b1110 : 4'b1011) : (r[17] ? 4'b0110 : 4'b0010);
                return {opc, r[27:16]};
            end
            default: begin
                // bit 5 picks right shift, bit 4 arithmetic
                case (r[22:21])
                    2'd0:    dir = 2'b00;
                    2'd1:    dir = 2'b10;
                    default: dir = 2'b11;
                endcase
                return {4'b1101, dr, sa, dir, r[26:23]};
            end
        endcase
    endfunction

    function automatic lc3b_word imem_word(lc3b_word addr);
        lc3b_word off;
        off = addr - P_RESET_PC;
        if (off[15:1] < N_INSTR) begin
            return prog_mem[off[15:1]];
        end
        return C_NOP_INSTR;
    endfunction

    // executes one fetched word and queues the write it must produce
    task automatic run_model(input lc3b_word w);
        lc3b_word a;
        lc3b_word b;
        lc3b_word res;
        lc3b_wb_t ent;
        int       kind;
        a    = model_regs[w[8:6]];
        b    = w[5] ? {{11{w[4]}}, w[4:0]} : model_regs[w[2:0]];
        kind = T_REG;
        case (w[15:12])
            4'b0001: res = a + b;
            4'b0101: res = a & b;
            4'b1001: res = ~a;
            4'b1101: begin
                kind = T_SHF;
                if (!w[5]) begin
                    res = a << w[3:0];
                end else if (w[4]) begin
                    res = $signed(a) >>> w[3:0];
                end else begin
                    res = a >> w[3:0];
                end
            end
            default: return;
        endcase
        ent.we   = 1'b1;
        ent.dest = w[11:9];
        ent.data = res;
        model_regs[w[11:9]] = res;
        exp_q.push_back(ent);
        kind_q.push_back(kind);
        exp_cnt++;
    endtask

    task automatic check_wb(input int t, input lc3b_wb_t exp, input lc3b_wb_t act);
        checks[t]++;
        if (act !== exp) begin
            errors[t]++;
            $display("Mismatch in %s: expected we=%0b r%0d=%h, actual we=%0b r%0d=%h",
                     test_name[t], exp.we, exp.dest, exp.data, act.we, act.dest, act.data);
        end
    endtask

    task automatic check_cc(input int t, input lc3b_nzp exp, input lc3b_nzp act);
        checks[t]++;
        if (act !== exp) begin
            errors[t]++;
            $display("Mismatch in %s: expected nzp=%b, actual nzp=%b", test_name[t], exp, act);
        end
    endtask

    task automatic check_addr(input int t, input lc3b_word exp, input lc3b_word act);
        checks[t]++;
        if (act !== exp) begin
            errors[t]++;
            $display("Mismatch in %s: expected address %h, actual %h", test_name[t], exp, act);
        end
    endtask

    task automatic report_test(input int t);
        $display("test %s: %0d checks, %0d errors", test_name[t], checks[t], errors[t]);
    endtask

    // memory answers each request after 0 to 3 idle cycles
    always @(posedge clk) begin
        if (i_arst_n) begin
            if (i_imem_resp) begin
                // the request completes at this edge and the pc moves on by 2
                next_delay = $unsigned($random(seed)) % 4;
                if (next_delay == 0) begin
                    i_imem_rdata <= imem_word(o_imem_address + 16'd2);
                end else begin
                    i_imem_resp <= 1'b0;
                    wait_cnt    <= next_delay - 1;
                end
            end else if (o_imem_read && wait_cnt == 0) begin
                i_imem_resp  <= 1'b1;
                i_imem_rdata <= imem_word(o_imem_address);
            end else if (o_imem_read) begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (i_arst_n && !done) begin
            if (first_cycle) begin
                first_cycle = 1'b0;
                checks[T_RESET]++;
                if (o_wb.we !== 1'b0) begin
                    errors[T_RESET]++;
                    $display("Mismatch in %s: expected we=0, actual we=%0b",
                             test_name[T_RESET], o_wb.we);
                end
                check_cc(T_RESET, 3'b000, o_cc);
            end
            if (o_wb.we === 1'b1) begin
                write_cnt++;
                if (exp_q.size() == 0) begin
                    errors[T_DONE]++;
                    $display("Unexpected write to r%0d while no write was pending", o_wb.dest);
                end else begin
                    exp_ent  = exp_q.pop_front();
                    exp_kind = kind_q.pop_front();
                    check_wb(exp_kind, exp_ent, o_wb);
                    last_cc = nzp_of(exp_ent.data);
                    check_cc(T_CC, last_cc, o_cc);
                end
            end else begin
                check_cc(T_CC, last_cc, o_cc);
            end
            if (i_imem_resp && o_imem_read) begin
                check_addr((fetch_cnt == 0) ? T_RESET : T_FETCH, exp_addr, o_imem_address);
                if (fetch_cnt == 0) begin
                    report_test(T_RESET);
                end
                exp_addr = exp_addr + 16'd2;
                if (fetch_cnt < N_INSTR) begin
                    run_model(prog_mem[fetch_cnt]);
                end
                fetch_cnt++;
            end
            if (fetch_cnt >= N_INSTR && exp_q.size() == 0) begin
                drain_cnt++;
                if (drain_cnt == 8) begin
                    done = 1'b1;
                end
            end
        end
    end

    initial begin
        cycle = 0;
        while (cycle < MAX_CYCLES) begin
            @(posedge clk);
            cycle++;
        end
        $display("Timeout: the run hung after %0d cycles with %0d writes still pending",
                 cycle, exp_q.size());
        $display("** FAIL **");
        $finish;
    end

    initial begin
        lc3b_reg     prev;
        logic [31:0] r;
        int          assert_fails;
        int          total_checks;
        int          total_errors;
        int          failed_tests;
        clk          = 1'b0;
        i_arst_n     = 1'b1;
        i_imem_resp  = 1'b0;
        i_imem_rdata = '0;
        seed         = 26;
        wait_cnt     = 0;
        next_delay   = 0;
        fetch_cnt    = 0;
        write_cnt    = 0;
        exp_cnt      = 0;
        drain_cnt    = 0;
        first_cycle  = 1'b1;
        done         = 1'b0;
        exp_addr     = P_RESET_PC;
        last_cc      = 3'b000;
        test_name    = '{"reset_state", "fetch_seq", "reg_results", "shifts", "cond_codes",
                         "completeness"};
        for (int t = 0; t < 6; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = 16'h0000;
        end
        prev = 3'd0;
        for (int i = 0; i < N_INSTR; i++) begin
            r           = $random(seed);
            prog_mem[i] = make_instr(r, prev);
            prev        = prog_mem[i][11:9];
        end
        // falling edge after time zero so the async reset is seen
        #1 i_arst_n = 1'b0;
        repeat (5) @(posedge clk);
        i_arst_n <= 1'b1;
        wait (done);
        checks[T_DONE]++;
        if (write_cnt != exp_cnt) begin
            errors[T_DONE]++;
            $display("Mismatch in %s: expected %0d writes, actual %0d writes",
                     test_name[T_DONE], exp_cnt, write_cnt);
        end
        if (exp_q.size() != 0) begin
            errors[T_DONE]++;
            $display("Writes still pending at the end of the run: %0d", exp_q.size());
        end
        for (int t = T_FETCH; t <= T_DONE; t++) begin
            report_test(t);
        end
        assert_fails = u_lc3b_core.u_lc3b_core_chk.n_fail;
        total_checks = 0;
        total_errors = 0;
        failed_tests = 0;
        for (int t = 0; t < 6; t++) begin
            total_checks += checks[t];
            total_errors += errors[t];
            if (errors[t] > 0) begin
                failed_tests++;
            end
        end
        $display("summary: 6 tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 failed_tests, total_checks, total_errors, assert_fails);
        if (total_errors == 0 && assert_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_lc3b_core

/* verilog.f */
rtl/lc3b_isa_pkg.sv
rtl/lc3b_pipe_pkg.sv
rtl/fetch_unit.sv
rtl/decode_stage.sv
rtl/regfile.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/lc3b_core.sv
tests/lc3b_core_chk.sv
tests/tb_lc3b_core.sv
